//--- design/mem_dev_pkg.sv
`default_nettype none

package mem_dev_pkg;

  localparam int MEM_ADDR_W  = 8;
  localparam int DATA_W      = 32;
  localparam int COUNT_W     = 24;
  localparam int HOST_ADDR_W = 64;

  typedef enum logic {
    FILL,
    READY
  } mem_fill_e;

  // Address step used by both transfer engines
  function automatic logic [MEM_ADDR_W-1:0] step_addr(
    input logic [MEM_ADDR_W-1:0] addr,
    input logic                  inc,
    input logic                  dec
  );
    if (inc) begin
      return addr + 1'b1;
    end
    if (dec) begin
      return addr - 1'b1;
    end
    return addr;
  endfunction

  // Counting pattern wraps after the last memory address
  function automatic logic [DATA_W-1:0] pattern_next(input logic [DATA_W-1:0] prev);
    if (prev == DATA_W'(2**MEM_ADDR_W - 1)) begin
      return '0;
    end
    return prev + 1'b1;
  endfunction

endpackage

`default_nettype wire

//--- design/ppfifo_pkg.sv
`default_nettype none

package ppfifo_pkg;

  localparam int FIFO_ADDR_W = 3;
  localparam int FIFO_DEPTH  = 2**FIFO_ADDR_W;
  localparam int BANKS       = 2;

  typedef enum logic [1:0] {
    EMPTY,
    FILLING,
    FULL,
    DRAINING
  } bank_state_e;

endpackage

`default_nettype wire

//--- design/pattern_mem.sv
`timescale 1ns/1ns
`default_nettype none

module pattern_mem
  import mem_dev_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   wr_en,
  input  wire  [MEM_ADDR_W-1:0] wr_addr,
  input  wire  [DATA_W-1:0]     wr_data,
  input  wire  [MEM_ADDR_W-1:0] rd_addr,
  output logic [DATA_W-1:0]     rd_data,
  output logic                  mem_ready
);

  logic [DATA_W-1:0]     mem [2**MEM_ADDR_W];
  mem_fill_e             state;
  logic [MEM_ADDR_W-1:0] fill_addr;
  logic                  mem_we;
  logic [MEM_ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0]     mem_din;

  assign mem_ready = (state == READY);

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= FILL;
      fill_addr <= '0;
    end else if (state == FILL) begin
      fill_addr <= fill_addr + 1'b1;
      if (fill_addr == '1) begin
        state <= READY;
      end
    end
  end

  // Fill sequencer owns the write port until the pattern is in place
  always_comb begin
    if (state == FILL) begin
      mem_we   = 1'b1;
      mem_addr = fill_addr;
      mem_din  = DATA_W'(fill_addr);
    end else begin
      mem_we   = wr_en;
      mem_addr = wr_addr;
      mem_din  = wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_din;
    end
    rd_data <= mem[rd_addr];
  end

  // Write engine must hold off until the fill is done
  assert property (@(posedge clk) disable iff (rst) (state == FILL) |-> !wr_en);

endmodule

`default_nettype wire

//--- design/ppfifo.sv
`timescale 1ns/1ns
`default_nettype none

module ppfifo
  import mem_dev_pkg::*;
  import ppfifo_pkg::*;
(
  input  wire                clk,
  input  wire                rst,
  output logic [BANKS-1:0]   write_ready,
  input  wire  [BANKS-1:0]   write_activate,
  output logic [COUNT_W-1:0] write_size,
  input  wire                write_strobe,
  input  wire  [DATA_W-1:0]  write_data,
  output logic               read_ready,
  input  wire                read_activate,
  output logic [COUNT_W-1:0] read_size,
  input  wire                read_strobe,
  output logic [DATA_W-1:0]  read_data
);

  bank_state_e            state [BANKS];
  logic [FIFO_ADDR_W:0]   count [BANKS];
  logic [DATA_W-1:0]      mem   [BANKS][FIFO_DEPTH];
  logic                   wr_bank;
  // Oldest committed bank
  logic                   head;
  logic [FIFO_ADDR_W-1:0] rd_ptr;

  assign wr_bank    = write_activate[1];
  assign write_size = COUNT_W'(FIFO_DEPTH);
  assign read_ready = (state[head] == FULL);
  assign read_size  = COUNT_W'(count[head]);
  assign read_data  = mem[head][rd_ptr];

  always_comb begin
    for (int i = 0; i < BANKS; i++) begin
      write_ready[i] = (state[i] == EMPTY);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= 1'b0;
      for (int i = 0; i < BANKS; i++) begin
        state[i] <= EMPTY;
        count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < BANKS; i++) begin
        case (state[i])
          EMPTY, FILLING: begin
            if (write_activate[i]) begin
              state[i] <= FILLING;
              if (write_strobe) begin
                count[i] <= count[i] + 1'b1;
              end
            end else if (state[i] == FILLING) begin
              state[i] <= (count[i] == '0) ? EMPTY : FULL;
              // Becomes head unless the other bank is already waiting or draining
              if (count[i] != '0 && state[BANKS-1-i] inside {EMPTY, FILLING}) begin
                head <= 1'(i);
              end
            end
          end
          FULL: begin
            if (read_activate && head == 1'(i)) begin
              state[i] <= DRAINING;
            end
          end
          DRAINING: begin
            if (!read_activate) begin
              state[i] <= EMPTY;
              count[i] <= '0;
              head     <= ~head;
            end
          end
          default: state[i] <= EMPTY;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write_strobe) begin
      mem[wr_bank][count[wr_bank][FIFO_ADDR_W-1:0]] <= write_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !read_activate) begin
      rd_ptr <= '0;
    end else if (read_strobe) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(&write_activate));
  assert property (@(posedge clk) disable iff (rst) write_strobe |-> |write_activate);
  assert property (@(posedge clk) disable iff (rst) read_strobe |-> read_activate);

endmodule

`default_nettype wire

//--- design/transfer_regs.sv
`timescale 1ns/1ns
`default_nettype none

module transfer_regs
  import mem_dev_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    write_enable,
  input  wire  [HOST_ADDR_W-1:0] write_addr,
  input  wire  [COUNT_W-1:0]     write_count,
  input  wire                    read_enable,
  input  wire  [HOST_ADDR_W-1:0] read_addr,
  input  wire  [COUNT_W-1:0]     read_count,
  input  wire                    mem_ready,
  output logic                   write_start,
  output logic [MEM_ADDR_W-1:0]  write_base,
  output logic [COUNT_W-1:0]     write_len,
  output logic                   read_start,
  output logic [MEM_ADDR_W-1:0]  read_base,
  output logic [COUNT_W-1:0]     read_len
);

  logic write_enable_q;
  logic read_enable_q;
  logic write_rise;
  logic read_rise;

  // Edges before the fill completes are dropped
  assign write_rise = mem_ready && write_enable && !write_enable_q;
  assign read_rise  = mem_ready && read_enable && !read_enable_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      write_enable_q <= 1'b0;
      read_enable_q  <= 1'b0;
      write_start    <= 1'b0;
      read_start     <= 1'b0;
    end else begin
      write_enable_q <= write_enable;
      read_enable_q  <= read_enable;
      write_start    <= write_rise;
      read_start     <= read_rise;
    end
  end

  always_ff @(posedge clk) begin
    if (write_rise) begin
      write_base <= write_addr[MEM_ADDR_W-1:0];
      write_len  <= write_count;
    end
    if (read_rise) begin
      read_base <= read_addr[MEM_ADDR_W-1:0];
      read_len  <= read_count;
    end
  end

endmodule

`default_nettype wire

//--- design/mem_write_engine.sv
`timescale 1ns/1ns
`default_nettype none

module mem_write_engine
  import mem_dev_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   start,
  input  wire  [MEM_ADDR_W-1:0] base,
  input  wire  [COUNT_W-1:0]    len,
  input  wire                   addr_inc,
  input  wire                   addr_dec,
  input  wire                   flush,
  input  wire                   fifo_ready,
  input  wire  [COUNT_W-1:0]    fifo_size,
  input  wire  [DATA_W-1:0]     fifo_data,
  output logic                  fifo_activate,
  output logic                  fifo_strobe,
  output logic                  mem_wr_en,
  output logic [MEM_ADDR_W-1:0] mem_wr_addr,
  output logic [DATA_W-1:0]     mem_wr_data,
  output logic                  finished,
  output logic                  pattern_error
);

  logic               armed;
  logic [COUNT_W-1:0] bank_cnt;
  logic [COUNT_W-1:0] written;
  logic               check_en;
  logic               pattern_ok;

  assign fifo_strobe = fifo_activate && (bank_cnt < fifo_size);
  assign finished    = armed && (written >= len);

  // mem_wr_data still holds the previous word here
  // first word of a bank may repeat it
  assign pattern_ok = (fifo_data == pattern_next(mem_wr_data)) ||
                      ((bank_cnt == '0) && (fifo_data == mem_wr_data));

  always_ff @(posedge clk) begin
    if (rst) begin
      armed         <= 1'b0;
      fifo_activate <= 1'b0;
      bank_cnt      <= '0;
      written       <= '0;
      check_en      <= 1'b0;
      mem_wr_en     <= 1'b0;
      pattern_error <= 1'b0;
    end else begin
      mem_wr_en     <= fifo_strobe;
      pattern_error <= fifo_strobe && check_en && !flush && !pattern_ok;
      if (start) begin
        armed    <= 1'b1;
        written  <= '0;
        check_en <= 1'b0;
      end else begin
        if (mem_wr_en) begin
          written <= written + 1'b1;
        end
        if (fifo_strobe) begin
          check_en <= 1'b1;
        end
      end
      // Claim a committed bank, drain it, then hand it back
      if (!fifo_activate) begin
        bank_cnt      <= '0;
        fifo_activate <= armed && fifo_ready;
      end else if (fifo_strobe) begin
        bank_cnt <= bank_cnt + 1'b1;
      end else begin
        fifo_activate <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_strobe) begin
      mem_wr_data <= fifo_data;
    end
    if (start) begin
      mem_wr_addr <= base;
    end else if (mem_wr_en) begin
      mem_wr_addr <= step_addr(mem_wr_addr, addr_inc, addr_dec);
    end
  end

endmodule

`default_nettype wire

//--- design/mem_read_engine.sv
`timescale 1ns/1ns
`default_nettype none

module mem_read_engine
  import mem_dev_pkg::*;
  import ppfifo_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   start,
  input  wire  [MEM_ADDR_W-1:0] base,
  input  wire  [COUNT_W-1:0]    len,
  input  wire                   enable,
  input  wire                   addr_inc,
  input  wire                   addr_dec,
  input  wire                   flush,
  input  wire  [DATA_W-1:0]     mem_rd_data,
  input  wire  [BANKS-1:0]      fifo_ready,
  input  wire  [COUNT_W-1:0]    fifo_size,
  output logic [MEM_ADDR_W-1:0] mem_rd_addr,
  output logic [BANKS-1:0]      fifo_activate,
  output logic                  fifo_strobe,
  output logic [DATA_W-1:0]     fifo_data,
  output logic                  busy,
  output logic                  pattern_error
);

  logic [COUNT_W-1:0] remaining;
  logic [COUNT_W-1:0] bank_cnt;
  logic               issue;
  logic               commit;
  logic               rd_valid;
  logic               check_en;
  logic [DATA_W-1:0]  prev_data;

  assign issue = enable && (remaining != '0) && (|fifo_activate) && (bank_cnt < fifo_size);

  // Wait for the last read to land before giving the bank up
  assign commit = (|fifo_activate) && !rd_valid &&
                  ((bank_cnt >= fifo_size) || (remaining == '0));

  // Memory data arrives one cycle after the read is issued
  assign fifo_strobe = rd_valid;
  assign fifo_data   = mem_rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      remaining     <= '0;
      bank_cnt      <= '0;
      fifo_activate <= '0;
      rd_valid      <= 1'b0;
      busy          <= 1'b0;
      check_en      <= 1'b0;
      pattern_error <= 1'b0;
    end else begin
      rd_valid      <= issue;
      pattern_error <= rd_valid && check_en && !flush &&
                       (mem_rd_data != pattern_next(prev_data));
      if (start) begin
        remaining <= len;
        busy      <= (len != '0);
        check_en  <= 1'b0;
      end else begin
        if (issue) begin
          remaining <= remaining - 1'b1;
        end
        if (commit && remaining == '0) begin
          busy <= 1'b0;
        end
        if (rd_valid) begin
          check_en <= 1'b1;
        end
      end
      // Lower free bank first
      if (fifo_activate == '0) begin
        bank_cnt <= '0;
        if (remaining != '0 && |fifo_ready) begin
          fifo_activate <= fifo_ready[0] ? BANKS'(1) : BANKS'(2);
        end
      end else if (issue) begin
        bank_cnt <= bank_cnt + 1'b1;
      end else if (commit) begin
        fifo_activate <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_valid) begin
      prev_data <= mem_rd_data;
    end
    if (start) begin
      mem_rd_addr <= base;
    end else if (issue) begin
      mem_rd_addr <= step_addr(mem_rd_addr, addr_inc, addr_dec);
    end
  end

  assert property (@(posedge clk) disable iff (rst) fifo_strobe |-> (|fifo_activate));

endmodule

`default_nettype wire

//--- design/test_mem_dev.sv
`timescale 1ns/1ns
`default_nettype none

module test_mem_dev
  import mem_dev_pkg::*;
  import ppfifo_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst,

  input  wire                    write_enable,
  input  wire  [HOST_ADDR_W-1:0] write_addr,
  input  wire                    write_addr_inc,
  input  wire                    write_addr_dec,
  output logic                   write_finished,
  input  wire  [COUNT_W-1:0]     write_count,
  input  wire                    write_flush,
  output logic                   write_error,

  output logic [BANKS-1:0]       write_ready,
  input  wire  [BANKS-1:0]       write_activate,
  output logic [COUNT_W-1:0]     write_size,
  input  wire                    write_strobe,
  input  wire  [DATA_W-1:0]      write_data,

  input  wire                    read_enable,
  input  wire  [HOST_ADDR_W-1:0] read_addr,
  input  wire                    read_addr_inc,
  input  wire                    read_addr_dec,
  output logic                   read_busy,
  output logic                   read_error,
  input  wire  [COUNT_W-1:0]     read_count,
  input  wire                    read_flush,

  output logic                   read_ready,
  output logic                   read_activate,
  output logic [COUNT_W-1:0]     read_size,
  output logic [DATA_W-1:0]      read_data,
  input  wire                    read_strobe
);

  logic                  mem_ready;
  logic                  mem_wr_en;
  logic [MEM_ADDR_W-1:0] mem_wr_addr;
  logic [DATA_W-1:0]     mem_wr_data;
  logic [MEM_ADDR_W-1:0] mem_rd_addr;
  logic [DATA_W-1:0]     mem_rd_data;

  logic                  write_start;
  logic [MEM_ADDR_W-1:0] write_base;
  logic [COUNT_W-1:0]    write_len;
  logic                  read_start;
  logic [MEM_ADDR_W-1:0] read_base;
  logic [COUNT_W-1:0]    read_len;

  logic                  f2m_ready;
  logic                  f2m_activate;
  logic                  f2m_strobe;
  logic [COUNT_W-1:0]    f2m_size;
  logic [DATA_W-1:0]     f2m_data;

  logic [BANKS-1:0]      m2f_ready;
  logic [BANKS-1:0]      m2f_activate;
  logic                  m2f_strobe;
  logic [COUNT_W-1:0]    m2f_size;
  logic [DATA_W-1:0]     m2f_data;

  logic [COUNT_W-1:0]    host_rd_cnt;

  pattern_mem mem_i (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (mem_wr_en),
    .wr_addr   (mem_wr_addr),
    .wr_data   (mem_wr_data),
    .rd_addr   (mem_rd_addr),
    .rd_data   (mem_rd_data),
    .mem_ready (mem_ready)
  );

  ppfifo fifo_to_mem_i (
    .clk            (clk),
    .rst            (rst),
    .write_ready    (write_ready),
    .write_activate (write_activate),
    .write_size     (write_size),
    .write_strobe   (write_strobe),
    .write_data     (write_data),
    .read_ready     (f2m_ready),
    .read_activate  (f2m_activate),
    .read_size      (f2m_size),
    .read_strobe    (f2m_strobe),
    .read_data      (f2m_data)
  );

  ppfifo mem_to_fifo_i (
    .clk            (clk),
    .rst            (rst),
    .write_ready    (m2f_ready),
    .write_activate (m2f_activate),
    .write_size     (m2f_size),
    .write_strobe   (m2f_strobe),
    .write_data     (m2f_data),
    .read_ready     (read_ready),
    .read_activate  (read_activate),
    .read_size      (read_size),
    .read_strobe    (read_strobe),
    .read_data      (read_data)
  );

  transfer_regs regs_i (
    .clk          (clk),
    .rst          (rst),
    .write_enable (write_enable),
    .write_addr   (write_addr),
    .write_count  (write_count),
    .read_enable  (read_enable),
    .read_addr    (read_addr),
    .read_count   (read_count),
    .mem_ready    (mem_ready),
    .write_start  (write_start),
    .write_base   (write_base),
    .write_len    (write_len),
    .read_start   (read_start),
    .read_base    (read_base),
    .read_len     (read_len)
  );

  mem_write_engine write_engine_i (
    .clk           (clk),
    .rst           (rst),
    .start         (write_start),
    .base          (write_base),
    .len           (write_len),
    .addr_inc      (write_addr_inc),
    .addr_dec      (write_addr_dec),
    .flush         (write_flush),
    .fifo_ready    (f2m_ready),
    .fifo_size     (f2m_size),
    .fifo_data     (f2m_data),
    .fifo_activate (f2m_activate),
    .fifo_strobe   (f2m_strobe),
    .mem_wr_en     (mem_wr_en),
    .mem_wr_addr   (mem_wr_addr),
    .mem_wr_data   (mem_wr_data),
    .finished      (write_finished),
    .pattern_error (write_error)
  );

  mem_read_engine read_engine_i (
    .clk           (clk),
    .rst           (rst),
    .start         (read_start),
    .base          (read_base),
    .len           (read_len),
    .enable        (read_enable),
    .addr_inc      (read_addr_inc),
    .addr_dec      (read_addr_dec),
    .flush         (read_flush),
    .mem_rd_data   (mem_rd_data),
    .fifo_ready    (m2f_ready),
    .fifo_size     (m2f_size),
    .mem_rd_addr   (mem_rd_addr),
    .fifo_activate (m2f_activate),
    .fifo_strobe   (m2f_strobe),
    .fifo_data     (m2f_data),
    .busy          (read_busy),
    .pattern_error (read_error)
  );

  // Host drains the outgoing FIFO by strobing only
  // the head bank is claimed for it and released after read_size strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      read_activate <= 1'b0;
      host_rd_cnt   <= '0;
    end else if (!read_activate) begin
      read_activate <= read_ready;
      host_rd_cnt   <= '0;
    end else if (read_strobe) begin
      host_rd_cnt <= host_rd_cnt + 1'b1;
      if (host_rd_cnt == read_size - 1'b1) begin
        read_activate <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/test_mem_dev_tb.sv
`timescale 1ns/1ns
`default_nettype none

module test_mem_dev_tb
  import mem_dev_pkg::*;
  import ppfifo_pkg::*;
();

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 5;
  localparam int TIMEOUT    = 1000;
  localparam int HOLD       = 0;
  localparam int INC        = 1;
  localparam int DEC        = 2;

  logic                   clk;
  logic                   rst;
  logic                   write_enable;
  logic [HOST_ADDR_W-1:0] write_addr;
  logic                   write_addr_inc;
  logic                   write_addr_dec;
  logic                   write_finished;
  logic [COUNT_W-1:0]     write_count;
  logic                   write_flush;
  logic                   write_error;
  logic [BANKS-1:0]       write_ready;
  logic [BANKS-1:0]       write_activate;
  logic [COUNT_W-1:0]     write_size;
  logic                   write_strobe;
  logic [DATA_W-1:0]      write_data;
  logic                   read_enable;
  logic [HOST_ADDR_W-1:0] read_addr;
  logic                   read_addr_inc;
  logic                   read_addr_dec;
  logic                   read_busy;
  logic                   read_error;
  logic [COUNT_W-1:0]     read_count;
  logic                   read_flush;
  logic                   read_ready;
  logic                   read_activate;
  logic [COUNT_W-1:0]     read_size;
  logic [DATA_W-1:0]      read_data;
  logic                   read_strobe;

  logic [DATA_W-1:0] shadow   [2**MEM_ADDR_W];
  logic [DATA_W-1:0] wr_words [64];
  logic [DATA_W-1:0] exp_q    [$];
  logic [7:0]        lfsr_state;
  logic              bank_open    = 1'b0;
  int                mismatch_cnt = 0;
  int                fail_cnt     = 0;
  int                rd_err_cnt   = 0;
  int                wr_err_cnt   = 0;

  test_mem_dev dut_i (
    .clk            (clk),
    .rst            (rst),
    .write_enable   (write_enable),
    .write_addr     (write_addr),
    .write_addr_inc (write_addr_inc),
    .write_addr_dec (write_addr_dec),
    .write_finished (write_finished),
    .write_count    (write_count),
    .write_flush    (write_flush),
    .write_error    (write_error),
    .write_ready    (write_ready),
    .write_activate (write_activate),
    .write_size     (write_size),
    .write_strobe   (write_strobe),
    .write_data     (write_data),
    .read_enable    (read_enable),
    .read_addr      (read_addr),
    .read_addr_inc  (read_addr_inc),
    .read_addr_dec  (read_addr_dec),
    .read_busy      (read_busy),
    .read_error     (read_error),
    .read_count     (read_count),
    .read_flush     (read_flush),
    .read_ready     (read_ready),
    .read_activate  (read_activate),
    .read_size      (read_size),
    .read_data      (read_data),
    .read_strobe    (read_strobe)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Counting rule wraps 255 to 0
  function automatic logic [DATA_W-1:0] next_count(input logic [DATA_W-1:0] v);
    return (v == 32'd255) ? 32'd0 : v + 32'd1;
  endfunction

  function automatic logic [MEM_ADDR_W-1:0] addr_at(
    input logic [MEM_ADDR_W-1:0] base,
    input int                    idx,
    input int                    mode
  );
    case (mode)
      INC:     return base + MEM_ADDR_W'(idx);
      DEC:     return base - MEM_ADDR_W'(idx);
      default: return base;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] expected_word(
    input logic [MEM_ADDR_W-1:0] base,
    input int                    idx,
    input int                    mode
  );
    return shadow[addr_at(base, idx, mode)];
  endfunction

  function automatic void shadow_write(
    input logic [MEM_ADDR_W-1:0] base,
    input int                    idx,
    input int                    mode,
    input logic [DATA_W-1:0]     value
  );
    shadow[addr_at(base, idx, mode)] = value;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("FAIL: %s", what);
    fail_cnt++;
  endtask

  always @(negedge clk) begin
    if (read_error) begin
      rd_err_cnt++;
    end
    if (write_error) begin
      wr_err_cnt++;
    end
  end

  // Every word the host takes is checked against the reference queue
  always @(negedge clk) begin
    int exp_size;
    if (!read_activate) begin
      bank_open = 1'b0;
    end else begin
      if (!bank_open && exp_q.size() != 0) begin
        exp_size = (exp_q.size() < FIFO_DEPTH) ? exp_q.size() : FIFO_DEPTH;
        check_value("read_size", 64'(read_size), 64'(exp_size));
      end
      bank_open = 1'b1;
      if (read_strobe) begin
        if (exp_q.size() == 0) begin
          report_failure("read FIFO delivered a word beyond the transfer");
        end else begin
          check_value("read_data", 64'(read_data), 64'(exp_q.pop_front()));
        end
      end
    end
  end

  task automatic run_write(
    input logic [MEM_ADDR_W-1:0] base,
    input int                    n,
    input logic [DATA_W-1:0]     first,
    input int                    skip_at,
    input logic                  flush
  );
    int waited;
    int idx;
    int exp_err;
    int err_start;
    for (int i = 0; i < n; i++) begin
      if (i == 0) begin
        wr_words[i] = first;
      end else if (i == skip_at) begin
        wr_words[i] = next_count(next_count(wr_words[i-1]));
      end else begin
        wr_words[i] = next_count(wr_words[i-1]);
      end
      shadow_write(base, i, INC, wr_words[i]);
    end
    exp_err = 0;
    for (int i = 1; i < n; i++) begin
      // A bank may open with a repeat of the last word
      if (!flush && wr_words[i] != next_count(wr_words[i-1]) &&
          !(i % FIFO_DEPTH == 0 && wr_words[i] == wr_words[i-1])) begin
        exp_err++;
      end
    end
    write_addr     = {32'h0000_00c3, 24'h0, base};
    write_count    = COUNT_W'(n);
    write_addr_inc = 1'b1;
    write_addr_dec = 1'b0;
    write_flush    = flush;
    write_enable   = 1'b1;
    // Start pulse lands two edges after the enable edge
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    err_start = wr_err_cnt;
    idx = 0;
    while (idx < n) begin
      waited = 0;
      while (write_ready == '0 && waited < TIMEOUT) begin
        @(posedge clk);
        #DRIVE_DLY;
        waited++;
      end
      if (write_ready == '0) begin
        report_failure("timeout waiting for an empty write bank");
        write_enable = 1'b0;
        return;
      end
      write_activate = write_ready[0] ? 2'b01 : 2'b10;
      @(posedge clk);
      #DRIVE_DLY;
      for (int k = 0; k < FIFO_DEPTH && idx < n; k++) begin
        write_strobe = 1'b1;
        write_data   = wr_words[idx];
        idx++;
        @(posedge clk);
        #DRIVE_DLY;
      end
      write_strobe   = 1'b0;
      write_activate = '0;
    end
    waited = 0;
    while (!write_finished && waited < TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end
    if (!write_finished) begin
      report_failure("timeout waiting for write_finished");
    end
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    write_enable = 1'b0;
    // Enable must be seen low before the next transfer raises it
    @(posedge clk);
    #DRIVE_DLY;
    check_value("write_error pulses", 64'(wr_err_cnt - err_start), 64'(exp_err));
  endtask

  task automatic run_read(
    input logic [MEM_ADDR_W-1:0] base,
    input int                    n,
    input int                    mode,
    input int                    stall
  );
    int                waited;
    int                taken;
    int                pause;
    int                exp_err;
    int                err_start;
    logic [DATA_W-1:0] w;
    logic [DATA_W-1:0] prev;
    exp_q.delete();
    exp_err = 0;
    prev    = '0;
    for (int i = 0; i < n; i++) begin
      w = expected_word(base, i, mode);
      if (i > 0 && w != next_count(prev)) begin
        exp_err++;
      end
      exp_q.push_back(w);
      prev = w;
    end
    err_start     = rd_err_cnt;
    read_addr     = {32'h0000_005a, 24'h0, base};
    read_count    = COUNT_W'(n);
    read_addr_inc = (mode == INC);
    read_addr_dec = (mode == DEC);
    read_enable   = 1'b1;
    waited = 0;
    while (!read_busy && waited < TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end
    if (!read_busy) begin
      report_failure("read_busy never rose after read_enable");
    end
    // Host side drains each bank after an optional pause
    taken  = 0;
    pause  = stall;
    waited = 0;
    while (taken < n && waited < TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
      if (!read_activate) begin
        read_strobe = 1'b0;
        pause       = stall;
      end else if (pause > 0) begin
        read_strobe = 1'b0;
        pause--;
      end else begin
        read_strobe = 1'b1;
        taken++;
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
    read_strobe = 1'b0;
    waited = 0;
    while (read_busy && waited < TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DLY;
      waited++;
    end
    if (read_busy) begin
      report_failure("read_busy stayed high after the transfer");
    end
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    read_enable = 1'b0;
    // Enable must be seen low before the next transfer raises it
    @(posedge clk);
    #DRIVE_DLY;
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d expected words were never delivered", exp_q.size()));
    end
    check_value("read_error pulses", 64'(rd_err_cnt - err_start), 64'(exp_err));
  endtask

  initial begin
    int                    n;
    logic [MEM_ADDR_W-1:0] base;
    lfsr_state = 8'd56;
    for (int a = 0; a < 2**MEM_ADDR_W; a++) begin
      shadow[a] = DATA_W'(a);
    end
    clk            = 1'b0;
    rst            = 1'b1;
    write_enable   = 1'b0;
    write_addr     = '0;
    write_addr_inc = 1'b0;
    write_addr_dec = 1'b0;
    write_count    = '0;
    write_flush    = 1'b0;
    write_activate = '0;
    write_strobe   = 1'b0;
    write_data     = '0;
    read_enable    = 1'b0;
    read_addr      = '0;
    read_addr_inc  = 1'b0;
    read_addr_dec  = 1'b0;
    read_count     = '0;
    read_flush     = 1'b0;
    read_strobe    = 1'b0;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    check_value("read_busy", 64'(read_busy), 64'(0));
    check_value("read_error", 64'(read_error), 64'(0));
    check_value("write_error", 64'(write_error), 64'(0));
    check_value("read_activate", 64'(read_activate), 64'(0));
    check_value("read_ready", 64'(read_ready), 64'(0));
    check_value("write_finished", 64'(write_finished), 64'(0));
    check_value("write_ready", 64'(write_ready), 64'(2'b11));
    check_value("write_size", 64'(write_size), 64'(FIFO_DEPTH));

    // Fill writes one word per cycle
    repeat (2**MEM_ADDR_W + 4) @(posedge clk);
    #DRIVE_DLY;

    run_read(MEM_ADDR_W'(rand_bits(8)), 16, INC, 0);

    n    = int'(rand_bits(4)) + 1;
    base = MEM_ADDR_W'(rand_bits(8));
    run_write(base, n, DATA_W'(rand_bits(8)), -1, 1'b0);
    run_read(base, n, INC, 0);

    run_read(MEM_ADDR_W'(rand_bits(8)), 10, DEC, 0);
    run_read(MEM_ADDR_W'(rand_bits(8)), 6, HOLD, 0);

    // One skipped value and the same run with flush
    base = MEM_ADDR_W'(rand_bits(8));
    run_write(base, 12, DATA_W'(rand_bits(8)), 5, 1'b0);
    run_write(base + 8'd40, 12, DATA_W'(rand_bits(8)), 9, 1'b1);
    run_read(base, 12, INC, 0);

    // Slow consumer fills both banks and stalls the engine
    run_read(MEM_ADDR_W'(rand_bits(8)), 20, INC, 12);

    repeat (4) @(posedge clk);
    $display("Run complete with %0d value mismatches and %0d other failures",
             mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test_mem_dev.f
design/mem_dev_pkg.sv
design/ppfifo_pkg.sv
design/pattern_mem.sv
design/ppfifo.sv
design/transfer_regs.sv
design/mem_write_engine.sv
design/mem_read_engine.sv
design/test_mem_dev.sv
tb/test_mem_dev_tb.sv

//--- Bender.yml
package:
  name: test_mem_dev

sources:
  - design/mem_dev_pkg.sv
  - design/ppfifo_pkg.sv
  - design/pattern_mem.sv
  - design/ppfifo.sv
  - design/transfer_regs.sv
  - design/mem_write_engine.sv
  - design/mem_read_engine.sv
  - design/test_mem_dev.sv
  - target: test
    files:
      - tb/test_mem_dev_tb.sv
